//--- Makefile
TOOL      = verilator
FLAGS     = --timing --assert
TOP       = coreTb
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/corePkg.sv
// Opcode and pipeline state types, imported by the modules that decode or track them
`include "core_settings.svh"

package corePkg;

	// Codes above OpHalt decode as OpNop
	typedef enum logic [`CORE_OPCODE_MSB-`CORE_OPCODE_LSB:0] {
		OpNop,
		OpAdd,
		OpSub,
		OpAnd,
		OpOr,
		OpXor,
		OpAddi,
		OpLoad,
		OpStore,
		OpBeq,
		OpHalt
	} coreOpcode;

	typedef enum logic [1:0] {
		StateRun,
		StateStall,
		StateHalted
	} pipeState;

endpackage

//--- design/executeUnit.sv
// Execute stage with forwarding, ALU, branch compare, data port request and writeback register
`include "core_settings.svh"

module executeUnit import corePkg::*; (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            stall,
	input  logic                            halted,
	input  coreOpcode                       exOpcode,
	input  logic [`CORE_REG_ADDR_WIDTH-1:0] exRsAddr,
	input  logic [`CORE_REG_ADDR_WIDTH-1:0] exRtAddr,
	input  logic [`CORE_REG_ADDR_WIDTH-1:0] exRdAddr,
	input  logic [`CORE_DATA_WIDTH-1:0]     exRsData,
	input  logic [`CORE_DATA_WIDTH-1:0]     exRtData,
	input  logic [`CORE_DATA_WIDTH-1:0]     exImm,
	input  logic [`CORE_DATA_WIDTH-1:0]     exPc,
	input  logic [`CORE_DATA_WIDTH-1:0]     dataRdData,
	input  logic                            dataReady,
	output logic [`CORE_DATA_WIDTH-1:0]     dataAddr,
	output logic [`CORE_DATA_WIDTH-1:0]     dataWrData,
	output logic                            dataWrite,
	output logic                            dataValid,
	output logic                            branchTaken,
	output logic [`CORE_DATA_WIDTH-1:0]     branchTarget,
	output logic                            haltSeen,
	output logic [`CORE_REG_ADDR_WIDTH-1:0] wbAddr,
	output logic [`CORE_DATA_WIDTH-1:0]     wbData,
	output logic                            wbEn
);
	logic [`CORE_DATA_WIDTH-1:0] opA;
	logic [`CORE_DATA_WIDTH-1:0] opB;
	logic [`CORE_DATA_WIDTH-1:0] aluResult;
	logic [`CORE_DATA_WIDTH-1:0] loadHold;
	logic [`CORE_DATA_WIDTH-1:0] loadData;
	logic                        isLoad;
	logic                        memOp;
	logic                        writesReg;
	logic                        memDone;

	// Writeback forwarding also covers a load followed by its user
	assign opA = (wbEn && wbAddr != '0 && wbAddr == exRsAddr) ? wbData : exRsData;
	assign opB = (wbEn && wbAddr != '0 && wbAddr == exRtAddr) ? wbData : exRtData;

	always_comb begin
		case (exOpcode)
			OpAdd: aluResult = opA + opB;
			OpSub: aluResult = opA - opB;
			OpAnd: aluResult = opA & opB;
			OpOr: aluResult = opA | opB;
			OpXor: aluResult = opA ^ opB;
			OpAddi, OpLoad, OpStore: aluResult = opA + exImm;
			default: aluResult = '0;
		endcase
	end

	assign isLoad = exOpcode == OpLoad;
	assign memOp = isLoad || exOpcode == OpStore;
	assign writesReg = exOpcode inside {OpAdd, OpSub, OpAnd, OpOr, OpXor, OpAddi, OpLoad};

	// A transfer that finishes while fetch still stalls must not be issued twice
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			memDone <= 1'b0;
		end else if (!stall) begin
			memDone <= 1'b0;
		end else if (dataValid && dataReady) begin
			memDone <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (dataValid && dataReady) begin
			loadHold <= dataRdData;
		end
	end

	assign loadData = memDone ? loadHold : dataRdData;

	assign dataValid = memOp && !halted && !memDone;
	assign dataWrite = exOpcode == OpStore;
	assign dataAddr = aluResult;
	assign dataWrData = opB;

	assign branchTaken = (exOpcode == OpBeq) && (opA == opB);
	assign branchTarget = exPc + `CORE_DATA_WIDTH'(1) + exImm;
	assign haltSeen = exOpcode == OpHalt;

	// Writeback register holds with the rest of the pipeline
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wbEn <= 1'b0;
		end else if (!stall) begin
			wbEn <= writesReg;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			wbAddr <= exRdAddr;
			wbData <= isLoad ? loadData : aluResult;
		end
	end

endmodule

//--- design/fetchDecode.sv
// Fetch and decode stages, from the instruction port to the decode/execute register
`include "core_settings.svh"

module fetchDecode import corePkg::*; (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [`CORE_DATA_WIDTH-1:0]     instrData,
	input  logic                            instrReady,
	input  logic                            stall,
	input  logic                            flush,
	input  logic                            halted,
	input  logic                            branchTaken,
	input  logic [`CORE_DATA_WIDTH-1:0]     branchTarget,
	input  logic [`CORE_DATA_WIDTH-1:0]     rsData,
	input  logic [`CORE_DATA_WIDTH-1:0]     rtData,
	output logic [`CORE_DATA_WIDTH-1:0]     instrAddr,
	output logic                            instrValid,
	output logic [`CORE_REG_ADDR_WIDTH-1:0] rsAddr,
	output logic [`CORE_REG_ADDR_WIDTH-1:0] rtAddr,
	output coreOpcode                       exOpcode,
	output logic [`CORE_REG_ADDR_WIDTH-1:0] exRsAddr,
	output logic [`CORE_REG_ADDR_WIDTH-1:0] exRtAddr,
	output logic [`CORE_REG_ADDR_WIDTH-1:0] exRdAddr,
	output logic [`CORE_DATA_WIDTH-1:0]     exRsData,
	output logic [`CORE_DATA_WIDTH-1:0]     exRtData,
	output logic [`CORE_DATA_WIDTH-1:0]     exImm,
	output logic [`CORE_DATA_WIDTH-1:0]     exPc
);
	logic [`CORE_DATA_WIDTH-1:0]                pc;
	logic                                       fetchDone;
	logic [`CORE_DATA_WIDTH-1:0]                idInstr;
	logic [`CORE_DATA_WIDTH-1:0]                idPc;
	logic [`CORE_OPCODE_MSB-`CORE_OPCODE_LSB:0] rawOp;
	coreOpcode                                  idOpcode;
	logic [`CORE_REG_ADDR_WIDTH-1:0]            idRdAddr;
	logic [`CORE_DATA_WIDTH-1:0]                idImm;

	assign instrValid = !halted;
	assign instrAddr = pc;
	assign fetchDone = instrValid && instrReady;

	// Branches are predicted not taken, so the PC only redirects from execute
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `CORE_DATA_WIDTH'(`CORE_RESET_PC);
		end else if (!stall) begin
			if (branchTaken) begin
				pc <= branchTarget;
			end else if (fetchDone) begin
				pc <= pc + `CORE_DATA_WIDTH'(1);
			end
		end
	end

	// Fetch/decode register holds a nop as all zeros
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idInstr <= '0;
		end else if (!stall) begin
			idInstr <= (flush || !fetchDone) ? '0 : instrData;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			idPc <= pc;
		end
	end

	assign rawOp = idInstr[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB];
	assign idOpcode = (rawOp <= OpHalt) ? coreOpcode'(rawOp) : OpNop;
	assign idRdAddr = idInstr[`CORE_RD_LSB +: `CORE_REG_ADDR_WIDTH];
	assign rsAddr = idInstr[`CORE_RS_LSB +: `CORE_REG_ADDR_WIDTH];

	// Store data and the beq compare operand come from rd
	assign rtAddr = (idOpcode == OpStore || idOpcode == OpBeq) ? idRdAddr :
		idInstr[`CORE_RT_LSB +: `CORE_REG_ADDR_WIDTH];

	assign idImm = {{(`CORE_DATA_WIDTH-`CORE_IMM_WIDTH){idInstr[`CORE_IMM_WIDTH-1]}},
		idInstr[`CORE_IMM_WIDTH-1:0]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exOpcode <= OpNop;
		end else if (!stall) begin
			exOpcode <= flush ? OpNop : idOpcode;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			exRsAddr <= rsAddr;
			exRtAddr <= rtAddr;
			exRdAddr <= idRdAddr;
			exRsData <= rsData;
			exRtData <= rtData;
			exImm <= idImm;
			exPc <= idPc;
		end
	end

endmodule

//--- design/pipelineControl.sv
// Pipeline control FSM that derives stall, flush and halted from the memory ports and execute
module pipelineControl import corePkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic instrValid,
	input  logic instrReady,
	input  logic dataValid,
	input  logic dataReady,
	input  logic branchTaken,
	input  logic haltSeen,
	output logic stall,
	output logic flush,
	output logic halted
);
	pipeState state;
	pipeState nextState;

	// Either port waiting freezes the whole pipeline
	assign stall = (instrValid && !instrReady) || (dataValid && !dataReady);

	always_comb begin
		if (state == StateHalted || (haltSeen && !stall)) begin
			nextState = StateHalted;
		end else if (stall) begin
			nextState = StateStall;
		end else begin
			nextState = StateRun;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= StateRun;
		end else begin
			state <= nextState;
		end
	end

	// Kills the two younger instructions when the pipeline next moves
	assign flush = branchTaken || haltSeen;
	assign halted = state == StateHalted;

endmodule

//--- design/processorCore.sv
// Top level of the four-stage core, exposing the instruction and data memory ports
`include "core_settings.svh"

module processorCore import corePkg::*; (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [`CORE_DATA_WIDTH-1:0] instrData,
	input  logic                        instrReady,
	input  logic [`CORE_DATA_WIDTH-1:0] dataRdData,
	input  logic                        dataReady,
	output logic [`CORE_DATA_WIDTH-1:0] instrAddr,
	output logic                        instrValid,
	output logic [`CORE_DATA_WIDTH-1:0] dataAddr,
	output logic [`CORE_DATA_WIDTH-1:0] dataWrData,
	output logic                        dataWrite,
	output logic                        dataValid,
	output logic                        halted
);
	logic                            stall;
	logic                            flush;
	logic                            branchTaken;
	logic [`CORE_DATA_WIDTH-1:0]     branchTarget;
	logic                            haltSeen;
	logic [`CORE_REG_ADDR_WIDTH-1:0] rsAddr;
	logic [`CORE_REG_ADDR_WIDTH-1:0] rtAddr;
	logic [`CORE_DATA_WIDTH-1:0]     rsData;
	logic [`CORE_DATA_WIDTH-1:0]     rtData;
	coreOpcode                       exOpcode;
	logic [`CORE_REG_ADDR_WIDTH-1:0] exRsAddr;
	logic [`CORE_REG_ADDR_WIDTH-1:0] exRtAddr;
	logic [`CORE_REG_ADDR_WIDTH-1:0] exRdAddr;
	logic [`CORE_DATA_WIDTH-1:0]     exRsData;
	logic [`CORE_DATA_WIDTH-1:0]     exRtData;
	logic [`CORE_DATA_WIDTH-1:0]     exImm;
	logic [`CORE_DATA_WIDTH-1:0]     exPc;
	logic [`CORE_REG_ADDR_WIDTH-1:0] wbAddr;
	logic [`CORE_DATA_WIDTH-1:0]     wbData;
	logic                            wbEn;

	fetchDecode fetchStage (
		.clk, .rst_n, .instrData, .instrReady, .instrAddr, .instrValid,
		.stall, .flush, .halted, .branchTaken, .branchTarget,
		.rsAddr, .rtAddr, .rsData, .rtData,
		.exOpcode, .exRsAddr, .exRtAddr, .exRdAddr, .exRsData, .exRtData, .exImm, .exPc
	);

	registerFile regFile (
		.clk, .rst_n, .rsAddr, .rtAddr, .rsData, .rtData,
		.wbAddr, .wbData, .wbEn
	);

	executeUnit execStage (
		.clk, .rst_n, .stall, .halted,
		.exOpcode, .exRsAddr, .exRtAddr, .exRdAddr, .exRsData, .exRtData, .exImm, .exPc,
		.dataRdData, .dataReady, .dataAddr, .dataWrData, .dataWrite, .dataValid,
		.branchTaken, .branchTarget, .haltSeen, .wbAddr, .wbData, .wbEn
	);

	pipelineControl control (
		.clk, .rst_n, .instrValid, .instrReady, .dataValid, .dataReady,
		.branchTaken, .haltSeen, .stall, .flush, .halted
	);

endmodule

//--- design/registerFile.sv
// Register file with two combinational read ports and a write-to-read bypass for decode
`include "core_settings.svh"

module registerFile (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [`CORE_REG_ADDR_WIDTH-1:0] rsAddr,
	input  logic [`CORE_REG_ADDR_WIDTH-1:0] rtAddr,
	input  logic [`CORE_REG_ADDR_WIDTH-1:0] wbAddr,
	input  logic [`CORE_DATA_WIDTH-1:0]     wbData,
	input  logic                            wbEn,
	output logic [`CORE_DATA_WIDTH-1:0]     rsData,
	output logic [`CORE_DATA_WIDTH-1:0]     rtData
);
	logic [`CORE_DATA_WIDTH-1:0] regs [`CORE_REG_COUNT];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn && wbAddr != '0) begin
			regs[wbAddr] <= wbData;
		end
	end

	// Register 0 reads zero and a write in flight is seen by decode
	assign rsData = (rsAddr == '0) ? '0 :
		(wbEn && wbAddr == rsAddr) ? wbData : regs[rsAddr];
	assign rtData = (rtAddr == '0) ? '0 :
		(wbEn && wbAddr == rtAddr) ? wbData : regs[rtAddr];

endmodule

//--- files.f
+incdir+include
design/corePkg.sv
design/registerFile.sv
design/fetchDecode.sv
design/executeUnit.sv
design/pipelineControl.sv
design/processorCore.sv
verif/coreTb.sv

//--- include/core_settings.svh
// Width, register file and instruction format macros shared by the RTL and the testbench
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data words, PC and instructions all use this width
`define CORE_DATA_WIDTH 32

`define CORE_REG_COUNT 32
`define CORE_REG_ADDR_WIDTH 5

// Word address of the first fetch
`define CORE_RESET_PC 0

// Instruction fields
`define CORE_OPCODE_MSB 31
`define CORE_OPCODE_LSB 26
`define CORE_RD_LSB 21
`define CORE_RS_LSB 16
`define CORE_RT_LSB 11
`define CORE_IMM_WIDTH 16

`endif

//--- verif/coreTb.sv
// Directed testbench for processorCore with instruction and data memory models and random waits
`include "core_settings.svh"

module coreTb import corePkg::*; ();
	localparam int InstrAddrBits = 6;
	localparam int DataAddrBits = 8;
	localparam int DataWords = 1 << DataAddrBits;
	localparam int MaxDelay = 3;
	localparam int TotalProgramWords = 49;
	// Every word may wait on both ports, plus resets, flushes and idle cycles after halt
	localparam int CycleLimit = TotalProgramWords * 2 * (MaxDelay + 1) + 400;

	logic clk;
	logic rst_n;
	logic [`CORE_DATA_WIDTH-1:0] instrData;
	logic [`CORE_DATA_WIDTH-1:0] instrAddr;
	logic [`CORE_DATA_WIDTH-1:0] dataRdData;
	logic [`CORE_DATA_WIDTH-1:0] dataAddr;
	logic [`CORE_DATA_WIDTH-1:0] dataWrData;
	logic instrReady;
	logic instrValid;
	logic dataReady;
	logic dataValid;
	logic dataWrite;
	logic halted;
	logic [`CORE_DATA_WIDTH-1:0] imem [1 << InstrAddrBits];
	logic [`CORE_DATA_WIDTH-1:0] dmem [DataWords];
	logic [31:0] lfsr;
	int instrWait;
	int dataWait;
	int mismatchCount;
	int failCount;

	processorCore DUT (
		.clk, .rst_n, .instrData, .instrReady, .dataRdData, .dataReady,
		.instrAddr, .instrValid, .dataAddr, .dataWrData, .dataWrite, .dataValid, .halted
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic randomBit();
		logic out;
		out = lfsr[0];
		lfsr = lfsr >> 1;
		if (out) begin
			lfsr = lfsr ^ 32'h80200003;
		end
		return out;
	endfunction

	function automatic int randomDelay();
		int delay;
		delay = 0;
		for (int i = 0; i < 2; i++) begin
			delay = delay * 2 + int'(randomBit());
		end
		return delay;
	endfunction

	function automatic logic [`CORE_DATA_WIDTH-1:0] regWord(coreOpcode op, int rd, int rs, int rt);
		logic [`CORE_DATA_WIDTH-1:0] word;
		word = '0;
		word[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB] = op;
		word[`CORE_RD_LSB +: `CORE_REG_ADDR_WIDTH] = rd[`CORE_REG_ADDR_WIDTH-1:0];
		word[`CORE_RS_LSB +: `CORE_REG_ADDR_WIDTH] = rs[`CORE_REG_ADDR_WIDTH-1:0];
		word[`CORE_RT_LSB +: `CORE_REG_ADDR_WIDTH] = rt[`CORE_REG_ADDR_WIDTH-1:0];
		return word;
	endfunction

	// Immediate shares its low bits with the rt field
	function automatic logic [`CORE_DATA_WIDTH-1:0] immWord(coreOpcode op, int rd, int rs, int imm);
		logic [`CORE_DATA_WIDTH-1:0] word;
		word = '0;
		word[`CORE_OPCODE_MSB:`CORE_OPCODE_LSB] = op;
		word[`CORE_RD_LSB +: `CORE_REG_ADDR_WIDTH] = rd[`CORE_REG_ADDR_WIDTH-1:0];
		word[`CORE_RS_LSB +: `CORE_REG_ADDR_WIDTH] = rs[`CORE_REG_ADDR_WIDTH-1:0];
		word[`CORE_IMM_WIDTH-1:0] = imm[`CORE_IMM_WIDTH-1:0];
		return word;
	endfunction

	function automatic logic [`CORE_DATA_WIDTH-1:0] fillWord(int addr);
		return 32'hDA7A0000 | `CORE_DATA_WIDTH'(addr);
	endfunction

	// Unused code space holds halts so a runaway PC stops
	task automatic clearMemories();
		for (int i = 0; i < (1 << InstrAddrBits); i++) begin
			imem[i] = immWord(OpHalt, 0, 0, i);
		end
		for (int i = 0; i < DataWords; i++) begin
			dmem[i] = fillWord(i);
		end
	endtask

	task automatic compareValue(string testName, string what,
		logic [`CORE_DATA_WIDTH-1:0] expected, logic [`CORE_DATA_WIDTH-1:0] actual);
		assert (actual === expected) else begin
			$display("mismatch %s %s: expected %h, actual %h", testName, what, expected, actual);
			mismatchCount++;
		end
	endtask

	task automatic compareMemory(string testName, int addr, logic [`CORE_DATA_WIDTH-1:0] expected);
		compareValue(testName, $sformatf("dmem[%0d]", addr), expected, dmem[addr]);
	endtask

	// Called at the falling edge, so a granted request completes at the next rising edge
	task automatic serveMemories();
		if (instrValid && instrWait == 0) begin
			instrReady = 1'b1;
			instrData = imem[instrAddr[InstrAddrBits-1:0]];
			instrWait = randomDelay();
		end else begin
			instrReady = 1'b0;
			if (instrWait > 0) begin
				instrWait--;
			end
		end
		assert (!dataValid || dataAddr < DataWords) else begin
			$display("ERROR: data access at %h is outside the memory model", dataAddr);
			failCount++;
		end
		if (dataValid && dataWait == 0) begin
			dataReady = 1'b1;
			if (dataWrite) begin
				dmem[dataAddr[DataAddrBits-1:0]] = dataWrData;
			end else begin
				dataRdData = dmem[dataAddr[DataAddrBits-1:0]];
			end
			dataWait = randomDelay();
		end else begin
			dataReady = 1'b0;
			if (dataWait > 0) begin
				dataWait--;
			end
		end
	endtask

	task automatic runProgram(string testName);
		rst_n = 1'b0;
		instrReady = 1'b0;
		dataReady = 1'b0;
		repeat (3) @(negedge clk);
		compareValue(testName, "reset instrAddr", `CORE_RESET_PC, instrAddr);
		compareValue(testName, "reset instrValid", 1, `CORE_DATA_WIDTH'(instrValid));
		compareValue(testName, "reset dataValid", 0, `CORE_DATA_WIDTH'(dataValid));
		compareValue(testName, "reset dataWrite", 0, `CORE_DATA_WIDTH'(dataWrite));
		compareValue(testName, "reset halted", 0, `CORE_DATA_WIDTH'(halted));
		rst_n = 1'b1;
		while (!halted) begin
			serveMemories();
			@(negedge clk);
		end
		// Stopped core keeps both ports idle
		repeat (4) begin
			serveMemories();
			@(negedge clk);
			compareValue(testName, "halted after halt", 1, `CORE_DATA_WIDTH'(halted));
			compareValue(testName, "instrValid after halt", 0, `CORE_DATA_WIDTH'(instrValid));
			compareValue(testName, "dataValid after halt", 0, `CORE_DATA_WIDTH'(dataValid));
		end
	endtask

	task automatic aluForwardingTest();
		logic [`CORE_DATA_WIDTH-1:0] v [1:7];
		v[1] = 1234;
		v[2] = v[1] - 300;
		v[3] = v[1] + v[2];
		v[4] = v[2] - v[3];
		v[5] = v[4] & v[3];
		v[6] = v[5] | v[1];
		v[7] = v[6] ^ v[4];
		clearMemories();
		imem[0] = immWord(OpAddi, 1, 0, 1234);
		imem[1] = immWord(OpAddi, 2, 1, -300);
		imem[2] = regWord(OpAdd, 3, 1, 2);
		imem[3] = regWord(OpSub, 4, 2, 3);
		imem[4] = regWord(OpAnd, 5, 4, 3);
		imem[5] = regWord(OpOr, 6, 5, 1);
		imem[6] = regWord(OpXor, 7, 6, 4);
		for (int i = 0; i < 5; i++) begin
			imem[7 + i] = immWord(OpStore, 7 - i, 0, 20 - i);
		end
		imem[12] = immWord(OpHalt, 0, 0, 0);
		runProgram("aluForwarding");
		for (int i = 3; i <= 7; i++) begin
			compareMemory("aluForwarding", 13 + i, v[i]);
		end
	endtask

	task automatic loadUseTest();
		clearMemories();
		imem[0] = immWord(OpAddi, 1, 0, 40);
		imem[1] = immWord(OpLoad, 2, 1, 0);
		imem[2] = immWord(OpLoad, 3, 1, 1);
		imem[3] = regWord(OpAdd, 4, 2, 3);
		imem[4] = immWord(OpStore, 4, 1, 10);
		imem[5] = regWord(OpSub, 5, 4, 2);
		imem[6] = immWord(OpStore, 5, 1, 11);
		imem[7] = immWord(OpLoad, 6, 1, 10);
		imem[8] = immWord(OpStore, 6, 1, 12);
		imem[9] = immWord(OpHalt, 0, 0, 0);
		runProgram("loadUse");
		compareMemory("loadUse", 50, fillWord(40) + fillWord(41));
		compareMemory("loadUse", 51, fillWord(41));
		compareMemory("loadUse", 52, fillWord(40) + fillWord(41));
	endtask

	task automatic branchTest();
		clearMemories();
		imem[0] = immWord(OpAddi, 1, 0, 7);
		imem[1] = immWord(OpAddi, 2, 0, 7);
		imem[2] = immWord(OpAddi, 3, 0, 9);
		imem[3] = immWord(OpBeq, 2, 1, 2);
		imem[4] = immWord(OpStore, 1, 0, 60);
		imem[5] = immWord(OpStore, 1, 0, 61);
		imem[6] = immWord(OpBeq, 3, 1, 1);
		imem[7] = immWord(OpStore, 3, 0, 62);
		imem[8] = immWord(OpBeq, 0, 0, 1);
		imem[9] = immWord(OpStore, 1, 0, 63);
		imem[10] = immWord(OpStore, 2, 0, 64);
		imem[11] = immWord(OpHalt, 0, 0, 0);
		runProgram("branch");
		compareMemory("branch", 60, fillWord(60));
		compareMemory("branch", 61, fillWord(61));
		compareMemory("branch", 62, 9);
		compareMemory("branch", 63, fillWord(63));
		compareMemory("branch", 64, 7);
	endtask

	task automatic haltTest();
		clearMemories();
		imem[0] = immWord(OpAddi, 1, 0, 33);
		imem[1] = immWord(OpStore, 1, 0, 70);
		imem[2] = immWord(OpHalt, 0, 0, 0);
		imem[3] = immWord(OpStore, 1, 0, 71);
		imem[4] = immWord(OpStore, 1, 0, 72);
		imem[5] = immWord(OpStore, 1, 0, 73);
		runProgram("halt");
		compareMemory("halt", 70, 33);
		for (int i = 71; i <= 73; i++) begin
			compareMemory("halt", i, fillWord(i));
		end
	endtask

	task automatic zeroRegisterTest();
		clearMemories();
		imem[0] = immWord(OpAddi, 0, 0, 99);
		imem[1] = regWord(OpAdd, 1, 0, 0);
		imem[2] = immWord(OpStore, 0, 0, 80);
		imem[3] = immWord(OpStore, 1, 0, 81);
		imem[4] = immWord(OpAddi, 2, 0, 5);
		imem[5] = regWord(OpAdd, 0, 2, 2);
		imem[6] = immWord(OpStore, 0, 0, 82);
		imem[7] = immWord(OpHalt, 0, 0, 0);
		runProgram("zeroRegister");
		for (int i = 80; i <= 82; i++) begin
			compareMemory("zeroRegister", i, 0);
		end
	endtask

	initial begin
		lfsr = 32'h9283d2e2;
		mismatchCount = 0;
		failCount = 0;
		rst_n = 1'b0;
		instrData = '0;
		instrReady = 1'b0;
		dataRdData = '0;
		dataReady = 1'b0;
		instrWait = randomDelay();
		dataWait = randomDelay();
		aluForwardingTest();
		loadUseTest();
		branchTest();
		haltTest();
		zeroRegisterTest();
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (CycleLimit) @(posedge clk);
		failCount++;
		$display("ERROR: timeout, the core did not halt within %0d cycles", CycleLimit);
		$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule
